/* source/board_pkg.sv */
// Shared widths, bus structs and register map; import into any block that needs them
package board_pkg;

    // ------------------------------
    // Widths that carry a meaning
    // ------------------------------
    typedef logic signed [15:0] sample_t;    // Audio sample to the DAC
    typedef logic signed [23:0] mic_word_t;  // Raw I2S mic word
    typedef logic        [15:0] level_t;     // Unsigned magnitude
    typedef logic        [ 3:0] reg_addr_t;  // APB word address
    typedef logic        [15:0] reg_data_t;  // APB register data

    // ------------------------------
    // APB port
    // ------------------------------
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        reg_addr_t paddr;
        reg_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        reg_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_phase_t;

    // Core steering; ctrl register packs disp_sel, vol_shift, mute in bits 5..0
    typedef struct packed {
        logic        mute;       // Silence the tone
        logic [3:0]  vol_shift;  // Arithmetic right shift of the phase
        logic        disp_sel;   // 0 shows tone step, 1 shows level
        reg_data_t   tone_step;  // Phase increment per frame
    } audio_cfg_t;

    localparam reg_addr_t ctrl_addr  = 4'd0;
    localparam reg_addr_t tone_addr  = 4'd1;
    localparam reg_addr_t level_addr = 4'd2;  // Read only
    localparam reg_addr_t id_addr    = 4'd3;  // Read only
    localparam reg_data_t id_word    = 16'ha0d1;

endpackage

/* source/tick_gen.sv */
// Periodic one-cycle enable strobe from clk; drives the display scan rate
module tick_gen #(
    parameter int clk_mhz = 50,
    parameter int scan_hz = 1000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int raw_period = clk_mhz * 1_000_000 / scan_hz;
    localparam int period     = (raw_period > 1) ? raw_period : 2;  // At least two cycles
    localparam int w_cnt      = $clog2(period);

    logic [w_cnt-1:0] cnt;  // Counts down to the next strobe

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= w_cnt'(period - 1);  // First strobe one full period after reset
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= w_cnt'(period - 1);  // Reload
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

/* source/i2s_mic_receiver.sv */
// I2S master for a 24-bit microphone; makes sck and ws, returns the left word with a strobe
module i2s_mic_receiver import board_pkg::*; #(
    parameter int bclk_div = 4  // clk cycles per half sck
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mic_sd,
    output logic      mic_sck,
    output logic      mic_ws,
    output mic_word_t mic_word,
    output logic      mic_valid
);

    localparam int w_div = (bclk_div > 1) ? $clog2(bclk_div) : 1;

    logic [w_div-1:0] div_cnt;    // Half sck period counter
    logic [5:0]       slot;       // sck position in the 64-bit frame
    logic [22:0]      shift_q;    // Bits taken so far
    logic             half_done;  // sck toggles this cycle
    logic             sck_rise;
    logic             sck_fall;
    logic             take_bit;
    logic             last_bit;

    assign half_done = (div_cnt == w_div'(bclk_div - 1));
    assign sck_rise  = half_done & ~mic_sck;  // Mic data is stable here
    assign sck_fall  = half_done & mic_sck;   // ws and slot move here
    assign take_bit  = sck_rise && (slot >= 6'd1) && (slot <= 6'd24);  // Left, after delay bit
    assign last_bit  = sck_rise && (slot == 6'd24);  // LSB of the word
    assign mic_ws    = slot[5];  // Low half is the left channel

    // ------------------------------
    // Clock and frame counters
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            mic_sck   <= 1'b0;
            slot      <= '0;
            mic_valid <= 1'b0;
        end else begin
            div_cnt   <= half_done ? '0 : div_cnt + 1'b1;
            mic_valid <= last_bit;  // Same edge as the word below
            if (half_done) begin
                mic_sck <= ~mic_sck;
            end
            if (sck_fall) begin
                slot <= slot + 1'b1;  // Wraps after 64, ws toggles every 32
            end
        end
    end

    // ------------------------------
    // Data capture, MSB first
    // ------------------------------
    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= {shift_q[21:0], mic_sd};
        end
        if (last_bit) begin
            mic_word <= mic_word_t'({shift_q, mic_sd});  // Full 24 bits
        end
    end

endmodule

/* source/i2s_audio_out.sv */
// I2S master transmitter for a 16-bit DAC; requests a sample per frame, sends it on both channels
module i2s_audio_out import board_pkg::*; #(
    parameter int clk_mhz  = 50,
    parameter int bclk_div = 4  // At least 2 clk cycles per half bclk
) (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sound,
    output logic    sample_req,
    output logic    aud_mclk,
    output logic    aud_bclk,
    output logic    aud_lrclk,
    output logic    aud_sdata
);

    localparam int mclk_half = (clk_mhz + 49) / 50;  // mclk stays at or below 25 MHz
    localparam int w_mclk    = (mclk_half > 1) ? $clog2(mclk_half) : 1;
    localparam int w_div     = (bclk_div > 1) ? $clog2(bclk_div) : 1;

    logic [w_mclk-1:0] mclk_cnt;
    logic [w_div-1:0]  div_cnt;
    logic [4:0]        slot;       // bclk position with 16 per channel
    logic              half_done;
    logic              bclk_fall;  // Data and lrclk change here
    logic              req_d;      // Core output is fresh
    sample_t           word_q;     // Held for the right channel
    sample_t           shift_q;

    assign half_done = (div_cnt == w_div'(bclk_div - 1));
    assign bclk_fall = half_done & aud_bclk;
    assign aud_lrclk = slot[4];  // Low is left

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mclk_cnt <= '0;
            aud_mclk <= 1'b0;
        end else if (mclk_cnt == w_mclk'(mclk_half - 1)) begin
            mclk_cnt <= '0;
            aud_mclk <= ~aud_mclk;
        end else begin
            mclk_cnt <= mclk_cnt + 1'b1;
        end
    end

    // ------------------------------
    // bclk, frame and serializer
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            aud_bclk   <= 1'b0;
            slot       <= '0;
            sample_req <= 1'b0;
            req_d      <= 1'b0;
            aud_sdata  <= 1'b0;
            word_q     <= '0;
            shift_q    <= '0;
        end else begin
            div_cnt    <= half_done ? '0 : div_cnt + 1'b1;
            sample_req <= bclk_fall && (slot == 5'd31);  // Left word-select edge
            req_d      <= sample_req;
            if (half_done) begin
                aud_bclk <= ~aud_bclk;
            end
            if (bclk_fall) begin
                slot      <= slot + 1'b1;
                aud_sdata <= shift_q[15];  // One-bit delay after lrclk
            end
            if (req_d) begin
                word_q  <= sound;  // Loads during the delay slot
                shift_q <= sound;
            end else if (bclk_fall && (slot == 5'd15)) begin
                shift_q <= word_q;  // Right repeats the left word
            end else if (bclk_fall) begin
                shift_q <= shift_q << 1;  // Next bit up to the MSB
            end
        end
    end

endmodule

/* source/seven_segment_scan.sv */
// Hex display driver; shows one nibble per digit, stepping on each scan tick
module seven_segment_scan import board_pkg::*; #(
    parameter int w_digit = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    input  reg_data_t          value,
    output logic [7:0]         abcdefgh,  // a in bit 7, dot in bit 0
    output logic [w_digit-1:0] digit      // One-hot, digit 0 is the LSB nibble
);

    localparam int w_idx = (w_digit > 1) ? $clog2(w_digit) : 1;

    logic [w_idx-1:0] idx;     // Digit shown at the next tick
    logic [3:0]       nibble;

    // Standard hex shapes, dot off
    function automatic logic [7:0] hex_seg(input logic [3:0] h);
        case (h)
            4'h0:    hex_seg = 8'b1111_1100;
            4'h1:    hex_seg = 8'b0110_0000;
            4'h2:    hex_seg = 8'b1101_1010;
            4'h3:    hex_seg = 8'b1111_0010;
            4'h4:    hex_seg = 8'b0110_0110;
            4'h5:    hex_seg = 8'b1011_0110;
            4'h6:    hex_seg = 8'b1011_1110;
            4'h7:    hex_seg = 8'b1110_0000;
            4'h8:    hex_seg = 8'b1111_1110;
            4'h9:    hex_seg = 8'b1111_0110;
            4'ha:    hex_seg = 8'b1110_1110;
            4'hb:    hex_seg = 8'b0011_1110;
            4'hc:    hex_seg = 8'b1001_1100;
            4'hd:    hex_seg = 8'b0111_1010;
            4'he:    hex_seg = 8'b1001_1110;
            default: hex_seg = 8'b1000_1110;  // F
        endcase
    endfunction

    assign nibble = 4'(value >> (4 * idx));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx      <= '0;
            abcdefgh <= '0;
            digit    <= '0;  // Dark until the first tick
        end else if (tick) begin
            abcdefgh <= hex_seg(nibble);
            digit    <= w_digit'(1) << idx;
            idx      <= (idx == w_idx'(w_digit - 1)) ? '0 : idx + 1'b1;
        end
    end

endmodule

/* source/audio_ctrl_regs.sv */
// APB register block; holds ctrl and tone settings and reads back the mic level
module audio_ctrl_regs import board_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  level_t     level,
    output audio_cfg_t cfg
);

    apb_phase_t phase;      // Phase seen in the last cycle
    apb_phase_t phase_nxt;
    logic       acc;        // Access phase, any address
    logic       bad_addr;   // Beyond the map
    logic       ro_write;   // Write to level or id
    logic       err;
    logic       wr_en;
    reg_data_t  rdata;

    // ------------------------------
    // Transfer phase tracker
    // ------------------------------
    always_comb begin
        if (!apb_req.psel) begin
            phase_nxt = apb_idle;
        end else if (!apb_req.penable) begin
            phase_nxt = apb_setup;
        end else begin
            phase_nxt = apb_access;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= apb_idle;
        end else begin
            phase <= phase_nxt;
        end
    end

    assign acc      = apb_req.psel & apb_req.penable;
    assign bad_addr = (apb_req.paddr > id_addr);
    assign ro_write = apb_req.pwrite &
                      ((apb_req.paddr == level_addr) | (apb_req.paddr == id_addr));
    assign err      = acc & (bad_addr | ro_write);
    assign wr_en    = acc & apb_req.pwrite & ~err & (phase == apb_setup);  // Once per transfer

    // ------------------------------
    // Read mux and response
    // ------------------------------
    always_comb begin
        case (apb_req.paddr)
            ctrl_addr:  rdata = reg_data_t'({cfg.disp_sel, cfg.vol_shift, cfg.mute});
            tone_addr:  rdata = cfg.tone_step;
            level_addr: rdata = level;
            id_addr:    rdata = id_word;
            default:    rdata = '0;
        endcase
    end

    assign apb_rsp.prdata  = acc ? rdata : '0;
    assign apb_rsp.pready  = acc;  // No wait states
    assign apb_rsp.pslverr = err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr_en) begin
            if (apb_req.paddr == ctrl_addr) begin
                {cfg.disp_sel, cfg.vol_shift, cfg.mute} <= apb_req.pwdata[5:0];
            end else begin
                cfg.tone_step <= apb_req.pwdata;  // Only tone is left writable
            end
        end
    end

endmodule

/* source/sound_lab_core.sv */
// Audio core; sawtooth tone with volume and mute, mic level and LED bar meter
module sound_lab_core import board_pkg::*; #(
    parameter int w_led = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  audio_cfg_t       cfg,
    input  mic_word_t        mic_word,
    input  logic             mic_valid,
    input  logic             sample_req,
    output sample_t          sound,
    output level_t           level,
    output logic [w_led-1:0] led
);

    sample_t          mic_top;    // Upper 16 bits of the mic word
    level_t           mag_nxt;
    level_t           mag_q;      // Magnitude stage
    logic             valid_d;
    logic [15:0]      phase;      // Sawtooth accumulator
    logic [15:0]      phase_nxt;
    logic [w_led-1:0] bar;

    // ------------------------------
    // Level meter
    // ------------------------------
    assign mic_top = sample_t'(mic_word[23:8]);

    always_comb begin
        if (mic_top == 16'sh8000) begin
            mag_nxt = 16'h7fff;  // Saturate the one value with no positive twin
        end else if (mic_top[15]) begin
            mag_nxt = level_t'(-mic_top);
        end else begin
            mag_nxt = level_t'(mic_top);
        end
    end

    always_comb begin
        for (int i = 0; i < w_led; i++) begin
            bar[i] = (int'(mag_q[15:12]) > i);  // Bar graph from the top nibble
        end
    end

    always_ff @(posedge clk) begin
        if (mic_valid) begin
            mag_q <= mag_nxt;
        end
    end

    // ------------------------------
    // Tone and outputs
    // ------------------------------
    assign phase_nxt = phase + cfg.tone_step;  // Modulo 65536

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
            level   <= '0;
            led     <= '0;
            phase   <= '0;
            sound   <= '0;
        end else begin
            valid_d <= mic_valid;
            if (valid_d) begin
                level <= mag_q;  // LEDs move with the level
                led   <= bar;
            end
            if (sample_req) begin
                phase <= phase_nxt;
                sound <= cfg.mute ? '0 : sample_t'($signed(phase_nxt) >>> cfg.vol_shift);
            end
        end
    end

endmodule

/* source/board_top.sv */
// Board-level wrapper for the audio lab; ties the blocks together and drives active-low pins
module board_top import board_pkg::*; #(
    parameter int clk_mhz  = 50,
    parameter int w_led    = 8,
    parameter int w_digit  = 4,
    parameter int scan_hz  = 1000,  // Digit step rate
    parameter int bclk_div = 4      // Shared by both I2S ports
) (
    input  logic               clk,
    input  logic               rst_n,
    input  apb_req_t           apb_req,
    output apb_rsp_t           apb_rsp,
    output logic [w_led-1:0]   led_n,
    output logic [7:0]         abcdefgh_n,
    output logic [w_digit-1:0] digit_n,
    input  logic               mic_sd,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               aud_mclk,
    output logic               aud_bclk,
    output logic               aud_lrclk,
    output logic               aud_sdata
);

    logic [w_led-1:0]   led;
    logic [7:0]         abcdefgh;
    logic [w_digit-1:0] digit;
    audio_cfg_t         cfg;
    level_t             level;
    mic_word_t          mic_word;
    logic               mic_valid;
    logic               sample_req;  // One per audio frame
    sample_t            sound;
    logic               tick;        // Scan enable
    reg_data_t          disp_value;

    // ------------------------------
    // Control and audio
    // ------------------------------
    audio_ctrl_regs i_regs (
        .clk, .rst_n, .apb_req, .apb_rsp, .level, .cfg
    );

    sound_lab_core #(.w_led(w_led)) i_core (
        .clk, .rst_n, .cfg, .mic_word, .mic_valid, .sample_req, .sound, .level, .led
    );

    i2s_mic_receiver #(.bclk_div(bclk_div)) i_microphone (
        .clk, .rst_n, .mic_sd, .mic_sck, .mic_ws, .mic_word, .mic_valid
    );

    i2s_audio_out #(.clk_mhz(clk_mhz), .bclk_div(bclk_div)) o_audio (
        .clk, .rst_n, .sound, .sample_req, .aud_mclk, .aud_bclk, .aud_lrclk, .aud_sdata
    );

    // ------------------------------
    // Display
    // ------------------------------
    assign disp_value = cfg.disp_sel ? level : cfg.tone_step;

    tick_gen #(.clk_mhz(clk_mhz), .scan_hz(scan_hz)) i_tick_gen (
        .clk, .rst_n, .tick
    );

    seven_segment_scan #(.w_digit(w_digit)) i_scan (
        .clk, .rst_n, .tick, .value(disp_value), .abcdefgh, .digit
    );

    // Board pins are active low
    assign led_n      = ~led;
    assign abcdefgh_n = ~abcdefgh;
    assign digit_n    = ~digit;

endmodule

/* tb/tb_clock_gen.sv */
// Free-running testbench clock; instantiate once and feed the DUT and the testbench
module tb_clock_gen #(
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;  // Known level at time zero
    end

    always begin
        #(period / 2) clk = ~clk;  // Half period high, half low
    end

endmodule

/* tb/tb_board_top.sv */
// Testbench for board_top; runs a table of APB, microphone, tone and display checks
module tb_board_top import board_pkg::*; ();

    localparam int bclk_div    = 2;
    localparam int scan_hz     = 5_000_000;          // Ten clk per digit
    localparam int frame_clk   = 32 * 2 * bclk_div;  // One audio frame
    localparam int n_rows      = 27;
    localparam int cycle_limit = n_rows * 4 * frame_clk;

    localparam logic [2:0] op_write = 3'd0;
    localparam logic [2:0] op_read  = 3'd1;
    localparam logic [2:0] op_mic   = 3'd2;
    localparam logic [2:0] op_tone  = 3'd3;
    localparam logic [2:0] op_disp  = 3'd4;

    typedef struct packed {
        logic [2:0] op;
        reg_addr_t  addr;
        reg_data_t  data;
        reg_data_t  exp;   // Expected read data
        logic       err;   // Expected pslverr
    } row_t;

    row_t rows [0:n_rows-1] = '{
        '{op_read,  4'd3,  16'h0000, 16'ha0d1, 1'b0},  // ID word
        '{op_write, 4'd0,  16'hffff, 16'h0000, 1'b0},
        '{op_read,  4'd0,  16'h0000, 16'h003f, 1'b0},  // Only six bits kept
        '{op_write, 4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_read,  4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_write, 4'd1,  16'h3a5c, 16'h0000, 1'b0},
        '{op_read,  4'd1,  16'h0000, 16'h3a5c, 1'b0},
        '{op_write, 4'd2,  16'h1234, 16'h0000, 1'b1},  // Read-only level
        '{op_write, 4'd3,  16'h1234, 16'h0000, 1'b1},  // Read-only id
        '{op_write, 4'd12, 16'h5555, 16'h0000, 1'b1},  // Unmapped
        '{op_read,  4'd7,  16'h0000, 16'h0000, 1'b1},
        '{op_read,  4'd1,  16'h0000, 16'h3a5c, 1'b0},  // Tone kept through the errors
        '{op_tone,  4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_write, 4'd0,  16'h0006, 16'h0000, 1'b0},  // Volume 3
        '{op_tone,  4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_write, 4'd0,  16'h0001, 16'h0000, 1'b0},  // Mute
        '{op_tone,  4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_write, 4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_tone,  4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_mic,   4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_mic,   4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_mic,   4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_disp,  4'd0,  16'h0000, 16'h0000, 1'b0},  // Shows tone step
        '{op_write, 4'd0,  16'h0020, 16'h0000, 1'b0},  // Display select
        '{op_disp,  4'd0,  16'h0000, 16'h0000, 1'b0},  // Shows level
        '{op_mic,   4'd0,  16'h0000, 16'h0000, 1'b0},
        '{op_disp,  4'd0,  16'h0000, 16'h0000, 1'b0}
    };

    logic       clk;
    logic       rst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic [7:0] led_n;
    logic [7:0] abcdefgh_n;
    logic [3:0] digit_n;
    logic       mic_sd;
    logic       mic_sck;
    logic       mic_ws;
    logic       aud_mclk;
    logic       aud_bclk;
    logic       aud_lrclk;
    logic       aud_sdata;

    int          errors;
    int          checks;
    int          cycles;
    logic [15:0] lfsr;          // Mic stimulus state
    logic [5:0]  ctrl_shadow;   // Last accepted ctrl write
    reg_data_t   tone_shadow;
    level_t      exp_level;
    sample_t     model_phase;   // Phase behind the captured words
    sample_t     left_q[$];     // Captured left words
    mic_word_t   mic_q[$];      // Words waiting for the mic model
    mic_word_t   mic_cur;
    int          mic_loaded;
    int          mic_pushed;

    tb_clock_gen #(.period(4)) u_clk (.clk);

    board_top #(.scan_hz(scan_hz), .bclk_div(bclk_div)) u_dut (
        .clk, .rst_n, .apb_req, .apb_rsp, .led_n, .abcdefgh_n, .digit_n,
        .mic_sd, .mic_sck, .mic_ws, .aud_mclk, .aud_bclk, .aud_lrclk, .aud_sdata
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // Galois form with taps 16 14 13 11
    endfunction

    // Segment pattern (a in bit 7) back to its hex digit, -1 if not a digit
    function automatic int seg_to_nibble(input logic [7:0] seg);
        case (seg)
            8'hfc: seg_to_nibble = 0;
            8'h60: seg_to_nibble = 1;
            8'hda: seg_to_nibble = 2;
            8'hf2: seg_to_nibble = 3;
            8'h66: seg_to_nibble = 4;
            8'hb6: seg_to_nibble = 5;
            8'hbe: seg_to_nibble = 6;
            8'he0: seg_to_nibble = 7;
            8'hfe: seg_to_nibble = 8;
            8'hf6: seg_to_nibble = 9;
            8'hee: seg_to_nibble = 10;
            8'h3e: seg_to_nibble = 11;
            8'h9c: seg_to_nibble = 12;
            8'h7a: seg_to_nibble = 13;
            8'h9e: seg_to_nibble = 14;
            8'h8e: seg_to_nibble = 15;
            default: seg_to_nibble = -1;
        endcase
    endfunction

    task automatic apb_transfer(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                                output reg_data_t rdata, output logic err);
        @(posedge clk);
        #1 apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #1 apb_req.penable = 1'b1;  // Access phase
        @(posedge clk);
        rdata = apb_rsp.prdata;      // Inputs still held so the response is stable
        err   = apb_rsp.pslverr;
        checks++;
        assert (apb_rsp.pready)
            else report_mismatch($sformatf("pready low in access at address %0d", addr));
        #1 apb_req = '0;
    endtask

    // mclk is clk divided by two, so it flips on every rising clk edge
    task automatic mclk_check();
        logic prev;
        prev = aud_mclk;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            checks++;
            assert (aud_mclk == !prev)
                else report_mismatch($sformatf("aud_mclk stuck at %b", aud_mclk));
            prev = aud_mclk;
        end
    endtask

    task automatic next_left_word(output sample_t w);
        while (left_q.size() == 0) begin
            @(posedge clk);
        end
        w = left_q.pop_front();
        model_phase = model_phase + sample_t'(tone_shadow);  // One step per frame
    endtask

    // ------------------------------
    // Operations
    // ------------------------------
    task automatic tone_check();
        sample_t w;
        sample_t prev;
        int      vol;
        logic    mute;
        vol  = ctrl_shadow[4:1];
        mute = ctrl_shadow[0];
        while (left_q.size() > 0) begin
            next_left_word(w);  // Words from before the change
        end
        next_left_word(w);
        next_left_word(prev);   // Settling frames
        for (int i = 0; i < 3; i++) begin
            next_left_word(w);
            checks++;
            if (mute) begin
                assert (w == 0) else report_mismatch($sformatf("muted word %h", w));
            end else if (vol == 0) begin
                assert (w == sample_t'(prev + tone_shadow))
                    else report_mismatch($sformatf("step %h after %h", w, prev));
                model_phase = w;  // Seed the phase model
            end else begin
                assert (w == (model_phase >>> vol))
                    else report_mismatch($sformatf("word %h, phase %h vol %0d",
                                                   w, model_phase, vol));
            end
            prev = w;
        end
    endtask

    task automatic mic_level_check();
        mic_word_t word;
        sample_t   top;
        reg_data_t rdata;
        logic      err;
        logic [7:0] exp_led_n;
        for (int b = 0; b < 24; b++) begin
            word = {word[22:0], lfsr[0]};  // One LFSR step per bit
            lfsr = lfsr_next(lfsr);
        end
        mic_q.push_back(word);
        mic_pushed++;
        while (mic_loaded < mic_pushed) begin
            @(posedge clk);
        end
        do begin
            @(posedge clk);
            #1;
        end while (!mic_ws);  // Left word has landed
        top = word[23:8];
        if (top == 16'sh8000) exp_level = 16'h7fff;
        else if (top < 0)     exp_level = -top;
        else                  exp_level = top;
        for (int i = 0; i < 8; i++) begin
            exp_led_n[i] = !(exp_level[15:12] > i);  // Dark above the bar
        end
        checks += 2;
        assert (led_n == exp_led_n)
            else report_mismatch($sformatf("led_n %b, expected %b", led_n, exp_led_n));
        apb_transfer(1'b0, level_addr, '0, rdata, err);
        assert (!err && rdata == exp_level)
            else report_mismatch($sformatf("level %h, expected %h", rdata, exp_level));
    endtask

    task automatic display_check();
        reg_data_t  value;
        logic [3:0] seen;
        logic [3:0] act;
        int         pass;
        int         idx;
        int         nib;
        value = ctrl_shadow[5] ? exp_level : tone_shadow;
        seen  = '0;
        pass  = 0;
        while (pass < 2) begin  // First scan may show the old value
            @(posedge clk);
            #1;
            act = ~digit_n;
            idx = -1;
            for (int d = 0; d < 4; d++) begin
                if (act == (4'b1 << d)) idx = d;
            end
            if (idx >= 0) begin
                seen[idx] = 1'b1;
                if (pass == 1) begin
                    nib = seg_to_nibble(~abcdefgh_n);
                    checks++;
                    assert (nib == int'(value[4*idx +: 4]))
                        else report_mismatch($sformatf("digit %0d shows %0d, value %h",
                                                       idx, nib, value));
                end
                if (seen == 4'hf) begin
                    pass++;
                    seen = '0;
                end
            end
        end
    endtask

    // ------------------------------
    // I2S models
    // ------------------------------
    logic    sck_prev;
    logic    ws_prev;
    int      bit_pos;
    logic    bclk_prev;
    logic    lr_prev;
    logic [15:0] aud_sh;
    int      aud_bits;
    sample_t last_left;

    always @(posedge clk) begin
        #1;
        if (!mic_sck && sck_prev) begin  // Falling sck
            if (!mic_ws && ws_prev) begin
                if (mic_q.size() > 0) begin
                    mic_cur = mic_q.pop_front();  // Else repeat the last word
                    mic_loaded++;
                end
                bit_pos = 0;  // Delay slot
            end else begin
                bit_pos++;
            end
            mic_sd = (bit_pos >= 1 && bit_pos <= 24) ? mic_cur[24 - bit_pos] : 1'b0;
        end
        sck_prev = mic_sck;
        ws_prev  = mic_ws;
    end

    always @(posedge clk) begin
        #1;
        if (aud_bclk && !bclk_prev) begin  // Rising bclk
            if (aud_lrclk != lr_prev && aud_bits >= 16) begin
                if (!lr_prev) begin
                    last_left = {aud_sh[14:0], aud_sdata};
                    left_q.push_back(last_left);
                end else begin
                    checks++;
                    assert ({aud_sh[14:0], aud_sdata} == last_left)
                        else report_mismatch("right word differs from left word");
                end
                aud_bits = 0;
            end
            aud_sh  = {aud_sh[14:0], aud_sdata};
            aud_bits++;
            lr_prev = aud_lrclk;
        end
        bclk_prev = aud_bclk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles, errors %0d",
                     cycle_limit, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        reg_data_t rdata;
        logic      err;
        rst_n = 1'b0;
        apb_req = '0;
        mic_sd = 1'b0;
        {errors, checks, cycles, mic_loaded, mic_pushed, bit_pos, aud_bits} = '0;
        {sck_prev, ws_prev, bclk_prev, lr_prev} = '0;
        {aud_sh, last_left, model_phase, mic_cur} = '0;
        {ctrl_shadow, tone_shadow, exp_level} = '0;
        lfsr = 16'd20;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        checks++;
        assert (led_n == 8'hff && digit_n == 4'hf && aud_sdata == 1'b0)
            else report_mismatch("outputs not idle after reset");
        mclk_check();
        for (int r = 0; r < n_rows; r++) begin
            case (rows[r].op)
                op_write, op_read: begin
                    apb_transfer(rows[r].op == op_write, rows[r].addr, rows[r].data,
                                 rdata, err);
                    checks++;
                    assert (err == rows[r].err)
                        else report_mismatch($sformatf("row %0d pslverr %b", r, err));
                    if (rows[r].op == op_read && !rows[r].err) begin
                        checks++;
                        assert (rdata == rows[r].exp)
                            else report_mismatch($sformatf("row %0d read %h, expected %h",
                                                           r, rdata, rows[r].exp));
                    end
                    if (rows[r].op == op_write && !rows[r].err) begin
                        if (rows[r].addr == ctrl_addr) ctrl_shadow = rows[r].data[5:0];
                        if (rows[r].addr == tone_addr) tone_shadow = rows[r].data;
                    end
                end
                op_mic:  mic_level_check();
                op_tone: tone_check();
                default: display_check();
            endcase
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/board_pkg.sv
source/tick_gen.sv
source/i2s_mic_receiver.sv
source/i2s_audio_out.sv
source/seven_segment_scan.sv
source/audio_ctrl_regs.sv
source/sound_lab_core.sv
source/board_top.sv
tb/tb_clock_gen.sv
tb/tb_board_top.sv

/* Bender.yml */
package:
  name: board_top

sources:
  - source/board_pkg.sv
  - source/tick_gen.sv
  - source/i2s_mic_receiver.sv
  - source/i2s_audio_out.sv
  - source/seven_segment_scan.sv
  - source/audio_ctrl_regs.sv
  - source/sound_lab_core.sv
  - source/board_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_board_top.sv
